/* compile.f */
rtl/mem_sub_pkg.sv
rtl/sram_bank.sv
rtl/exit_monitor.sv
rtl/mem_router.sv
rtl/mem_sub_top.sv
tests/tb_clock_gen.sv
tests/tb_mem_sub.sv

/* run.sh */
#!/bin/sh
# Builds the memory subsystem testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=sim_mem_sub
LOG_FILE=sim.log

verilator --binary --timing -f compile.f --top-module tb_mem_sub \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
cat "$LOG_FILE"

if grep -q "^TEST PASS$" "$LOG_FILE"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tests/tb_mem_sub.sv */
// Table-driven testbench for the memory subsystem, checks routing, banks and exit reporting
module tb_mem_sub;
  timeunit 1ns;
  timeprecision 1ps;

  import mem_sub_pkg::*;

  localparam int RESET_TIMEOUT = 10;
  localparam int RESP_TIMEOUT  = 8;

  typedef struct packed {
    logic  is_ext;
    logic  is_write;
    addr_t addr;
    strb_t be;
    logic  use_lfsr;
    data_t data;
  } stim_t;

  logic       clk;
  logic       arst_n;
  logic       req;
  logic       we;
  addr_t      addr;
  strb_t      be;
  data_t      wdata;
  data_t      rdata;
  logic       rvalid;
  logic       ext_active;
  logic       ext_req;
  logic       ext_we;
  addr_t      ext_addr;
  strb_t      ext_be;
  data_t      ext_wdata;
  data_t      ext_rdata;
  logic       ext_rvalid;
  logic       exit_valid;
  exit_code_t exit_code;

  // Reference state
  data_t      main_ref [MAIN_WORDS];
  data_t      user_ref [USER_WORDS];
  logic       pend_read;
  data_t      pend_data;
  logic       exp_exit_valid;
  exit_code_t exp_exit_code;

  stim_t       stim_q [$];
  logic [15:0] lfsr_q;
  int          error_count;
  int          check_count;

  tb_clock_gen u_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mem_sub_top u_mem_sub_top (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .be_i         (be),
    .wdata_i      (wdata),
    .rdata_o      (rdata),
    .rvalid_o     (rvalid),
    .ext_active_i (ext_active),
    .ext_req_o    (ext_req),
    .ext_we_o     (ext_we),
    .ext_addr_o   (ext_addr),
    .ext_be_o     (ext_be),
    .ext_wdata_o  (ext_wdata),
    .ext_rdata_i  (ext_rdata),
    .ext_rvalid_i (ext_rvalid),
    .exit_valid_o (exit_valid),
    .exit_code_o  (exit_code)
  );

  // ----------------------------------------
  // Random source
  // ----------------------------------------
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic data_t random_bits(input int n);
    data_t result;
    result = '0;
    for (int i = 0; i < n; i++) begin
      result = {result[DATA_W-2:0], lfsr_step()};
    end
    return result;
  endfunction

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic int main_index(input addr_t a);
    addr_t off;
    off = a - MAIN_BASE;
    return int'((off / WORD_BYTES) % MAIN_WORDS);
  endfunction

  function automatic int user_index(input addr_t a);
    addr_t off;
    off = a - USER_BASE;
    return int'((off / WORD_BYTES) % USER_WORDS);
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t en);
    data_t result;
    result = old_word;
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (en[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  function automatic void update_model(input stim_t s, input data_t wd);
    int idx;
    pend_read = 1'b0;
    // Exit detection sees the core port whatever the routing
    if (s.is_write && s.addr == TOHOST_ADDR && wd[0] && !exp_exit_valid) begin
      exp_exit_valid = 1'b1;
      exp_exit_code  = wd[31:0] >> 1;
    end
    if (!s.is_ext) begin
      if (s.addr >= USER_BASE) begin
        idx = user_index(s.addr);
        if (s.is_write) begin
          user_ref[idx] = merge_bytes(user_ref[idx], wd, s.be);
        end else begin
          pend_read = 1'b1;
          pend_data = user_ref[idx];
        end
      end else begin
        idx = main_index(s.addr);
        if (s.is_write) begin
          main_ref[idx] = merge_bytes(main_ref[idx], wd, s.be);
        end else begin
          pend_read = 1'b1;
          pend_data = main_ref[idx];
        end
      end
    end
  endfunction

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic report_mismatch(input string name, input data_t expected, input data_t actual);
    error_count++;
    $display("ERROR %s: expected 0x%0h, got 0x%0h", name, expected, actual);
  endtask

  // Sampled on the falling edge, covers the request of the previous cycle
  task automatic check_response();
    check_count += 3;
    if (rvalid !== pend_read) begin
      report_mismatch("rvalid_o", 64'(pend_read), 64'(rvalid));
    end
    if (pend_read) begin
      check_count++;
      if (rdata !== pend_data) begin
        report_mismatch("rdata_o", pend_data, rdata);
      end
    end
    if (exit_valid !== exp_exit_valid) begin
      report_mismatch("exit_valid_o", 64'(exp_exit_valid), 64'(exit_valid));
    end
    if (exit_code !== exp_exit_code) begin
      report_mismatch("exit_code_o", 64'(exp_exit_code), 64'(exit_code));
    end
  endtask

  task automatic check_ext_outputs(input stim_t s, input data_t wd);
    logic  exp_req;
    logic  exp_we;
    addr_t exp_addr;
    strb_t exp_be;
    data_t exp_wdata;
    exp_req   = s.is_ext;
    exp_we    = s.is_ext & s.is_write;
    exp_addr  = s.is_ext ? s.addr : '0;
    exp_be    = s.is_ext ? s.be : '0;
    exp_wdata = s.is_ext ? wd : '0;
    check_count += 5;
    if (ext_req !== exp_req) begin
      report_mismatch("ext_req_o", 64'(exp_req), 64'(ext_req));
    end
    if (ext_we !== exp_we) begin
      report_mismatch("ext_we_o", 64'(exp_we), 64'(ext_we));
    end
    if (ext_addr !== exp_addr) begin
      report_mismatch("ext_addr_o", 64'(exp_addr), 64'(ext_addr));
    end
    if (ext_be !== exp_be) begin
      report_mismatch("ext_be_o", 64'(exp_be), 64'(ext_be));
    end
    if (ext_wdata !== exp_wdata) begin
      report_mismatch("ext_wdata_o", exp_wdata, ext_wdata);
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  function automatic void add_entry(input logic ext, input logic wr, input addr_t a,
                                    input strb_t en, input logic rnd, input data_t d);
    stim_t s;
    s.is_ext   = ext;
    s.is_write = wr;
    s.addr     = a;
    s.be       = en;
    s.use_lfsr = rnd;
    s.data     = d;
    stim_q.push_back(s);
  endfunction

  function automatic void build_table();
    // ext, write, address, byte enables, LFSR data, fixed data
    add_entry(1'b0, 1'b1, 32'h8000_0040, 8'hFF, 1'b0, 64'h1111_2222_3333_4444);
    add_entry(1'b0, 1'b1, 32'h8000_0040, 8'h0F, 1'b0, 64'hAAAA_BBBB_CCCC_DDDD);
    add_entry(1'b0, 1'b0, 32'h8000_0040, 8'hFF, 1'b0, 64'h0);
    add_entry(1'b0, 1'b1, 32'h8000_0048, 8'hF0, 1'b1, 64'h0);
    // Back-to-back reads
    add_entry(1'b0, 1'b0, 32'h8000_0048, 8'hFF, 1'b0, 64'h0);
    add_entry(1'b0, 1'b0, 32'h8000_0040, 8'hFF, 1'b0, 64'h0);
    add_entry(1'b0, 1'b0, 32'h8000_0048, 8'hFF, 1'b0, 64'h0);
    // Same offset in main and user memory
    add_entry(1'b0, 1'b1, 32'h8000_0080, 8'hFF, 1'b1, 64'h0);
    add_entry(1'b0, 1'b1, 32'h8400_0080, 8'hFF, 1'b1, 64'h0);
    add_entry(1'b0, 1'b0, 32'h8000_0080, 8'hFF, 1'b0, 64'h0);
    add_entry(1'b0, 1'b0, 32'h8400_0080, 8'hFF, 1'b0, 64'h0);
    // Aliasing one bank depth apart
    add_entry(1'b0, 1'b1, 32'h8000_0100, 8'hFF, 1'b0, 64'h0123_4567_89AB_CDEF);
    add_entry(1'b0, 1'b1, 32'h8000_0900, 8'hC3, 1'b1, 64'h0);
    add_entry(1'b0, 1'b0, 32'h8000_0100, 8'hFF, 1'b0, 64'h0);
    add_entry(1'b0, 1'b1, 32'h8400_0010, 8'hFF, 1'b1, 64'h0);
    add_entry(1'b0, 1'b0, 32'h8400_0210, 8'hFF, 1'b0, 64'h0);
    // External slave path
    add_entry(1'b1, 1'b1, 32'h8000_0040, 8'hFF, 1'b1, 64'h0);
    add_entry(1'b1, 1'b0, 32'h8000_0040, 8'hFF, 1'b0, 64'h0);
    add_entry(1'b1, 1'b0, 32'h9000_0000, 8'hFF, 1'b0, 64'h0);
    add_entry(1'b1, 1'b1, 32'h8400_0080, 8'h3C, 1'b0, 64'hDEAD_BEEF_CAFE_F00D);
    add_entry(1'b0, 1'b0, 32'h8000_0040, 8'hFF, 1'b0, 64'h0);
    add_entry(1'b0, 1'b0, 32'h8400_0080, 8'hFF, 1'b0, 64'h0);
    // Exit reporting, tohost shares main word 0
    add_entry(1'b0, 1'b1, TOHOST_ADDR,   8'hFF, 1'b0, 64'h0000_0000_0000_0054);
    add_entry(1'b0, 1'b0, TOHOST_ADDR,   8'hFF, 1'b0, 64'h0);
    add_entry(1'b0, 1'b1, TOHOST_ADDR,   8'hFF, 1'b0, 64'h0000_0000_0000_002B);
    add_entry(1'b0, 1'b1, TOHOST_ADDR,   8'hFF, 1'b0, 64'h0000_0000_0000_0063);
    add_entry(1'b0, 1'b0, TOHOST_ADDR,   8'hFF, 1'b0, 64'h0);
    add_entry(1'b0, 1'b0, 32'h8000_0000, 8'hFF, 1'b0, 64'h0);
  endfunction

  task automatic idle_core_port();
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    be    = '0;
    wdata = '0;
  endtask

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (arst_n !== 1'b1) begin
      error_count++;
      $display("Timeout: reset was never released");
    end
  endtask

  // Plays the external slave, answering after 1 to 3 cycles
  task automatic serve_ext_read();
    data_t rnd;
    data_t ext_val;
    int    delay;
    int    cycles;
    logic  seen;
    rnd     = random_bits(2);
    delay   = 1 + (int'(rnd[1:0]) % 3);
    ext_val = random_bits(64);
    seen    = 1'b0;
    cycles  = 0;
    while (!seen && cycles < RESP_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      idle_core_port();
      ext_rvalid = (cycles == delay);
      ext_rdata  = (cycles == delay) ? ext_val : '0;
      @(posedge clk);
      seen = rvalid;
    end
    if (!seen) begin
      error_count++;
      $display("Timeout: no read response on the external path after %0d cycles", cycles);
    end else begin
      check_count += 2;
      if (cycles != delay) begin
        report_mismatch("rvalid_o latency", 64'(delay), 64'(cycles));
      end
      if (rdata !== ext_val) begin
        report_mismatch("rdata_o", ext_val, rdata);
      end
    end
    @(negedge clk);
    ext_rvalid = 1'b0;
    ext_rdata  = '0;
  endtask

  task automatic run_entry(input stim_t s);
    data_t wd;
    @(negedge clk);
    check_response();
    wd         = s.use_lfsr ? random_bits(64) : s.data;
    ext_active = s.is_ext;
    req        = 1'b1;
    we         = s.is_write;
    addr       = s.addr;
    be         = s.be;
    wdata      = wd;
    ext_rvalid = 1'b0;
    ext_rdata  = '0;
    update_model(s, wd);
    @(posedge clk);
    check_ext_outputs(s, wd);
    if (s.is_ext && !s.is_write) begin
      serve_ext_read();
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    lfsr_q         = 16'd48934;
    error_count    = 0;
    check_count    = 0;
    pend_read      = 1'b0;
    pend_data      = '0;
    exp_exit_valid = 1'b0;
    exp_exit_code  = '0;
    ext_active     = 1'b0;
    ext_rvalid     = 1'b0;
    ext_rdata      = '0;
    idle_core_port();
    foreach (main_ref[i]) main_ref[i] = '0;
    foreach (user_ref[i]) user_ref[i] = '0;
    build_table();

    wait_for_reset();
    @(negedge clk);
    check_count += 3;
    if (rvalid !== 1'b0) begin
      report_mismatch("rvalid_o", 64'h0, 64'(rvalid));
    end
    if (exit_valid !== 1'b0) begin
      report_mismatch("exit_valid_o", 64'h0, 64'(exit_valid));
    end
    if (ext_req !== 1'b0) begin
      report_mismatch("ext_req_o", 64'h0, 64'(ext_req));
    end

    foreach (stim_q[i]) begin
      run_entry(stim_q[i]);
    end

    // Collect the last response
    @(negedge clk);
    check_response();
    idle_core_port();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* tests/tb_clock_gen.sv */
// Testbench clock and reset source, 40 ns clock with reset held low for two cycles
module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD  = 20ns;
  localparam int  RESET_CYCLES = 2;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

  // Release on a falling edge, away from the active clock edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* rtl/mem_sub_top.sv */
// Memory subsystem top level, connects the core port to the router, both banks and exit monitor
module mem_sub_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Core request
  input  logic                   req_i,
  input  logic                   we_i,
  input  mem_sub_pkg::addr_t     addr_i,
  input  mem_sub_pkg::strb_t     be_i,
  input  mem_sub_pkg::data_t     wdata_i,
  // Core response
  output mem_sub_pkg::data_t     rdata_o,
  output logic                   rvalid_o,
  // External slave select
  input  logic                   ext_active_i,
  // External request
  output logic                   ext_req_o,
  output logic                   ext_we_o,
  output mem_sub_pkg::addr_t     ext_addr_o,
  output mem_sub_pkg::strb_t     ext_be_o,
  output mem_sub_pkg::data_t     ext_wdata_o,
  // External response
  input  mem_sub_pkg::data_t     ext_rdata_i,
  input  logic                   ext_rvalid_i,
  // End of test
  output logic                   exit_valid_o,
  output mem_sub_pkg::exit_code_t exit_code_o
);
  import mem_sub_pkg::*;

  // Main bank side
  logic                          main_req;
  logic                          main_we;
  logic [$clog2(MAIN_WORDS)-1:0] main_idx;
  strb_t                         main_be;
  data_t                         main_wdata;
  data_t                         main_rdata;

  // User bank side
  logic                          user_req;
  logic                          user_we;
  logic [$clog2(USER_WORDS)-1:0] user_idx;
  strb_t                         user_be;
  data_t                         user_wdata;
  data_t                         user_rdata;

  mem_router u_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .be_i         (be_i),
    .wdata_i      (wdata_i),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .ext_active_i (ext_active_i),
    .ext_req_o    (ext_req_o),
    .ext_we_o     (ext_we_o),
    .ext_addr_o   (ext_addr_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_rdata_i  (ext_rdata_i),
    .ext_rvalid_i (ext_rvalid_i),
    .main_req_o   (main_req),
    .main_we_o    (main_we),
    .main_idx_o   (main_idx),
    .main_be_o    (main_be),
    .main_wdata_o (main_wdata),
    .main_rdata_i (main_rdata),
    .user_req_o   (user_req),
    .user_we_o    (user_we),
    .user_idx_o   (user_idx),
    .user_be_o    (user_be),
    .user_wdata_o (user_wdata),
    .user_rdata_i (user_rdata)
  );

  sram_bank #(
    .NUM_WORDS (MAIN_WORDS)
  ) u_main_bank (
    .clk_i   (clk_i),
    .req_i   (main_req),
    .we_i    (main_we),
    .idx_i   (main_idx),
    .be_i    (main_be),
    .wdata_i (main_wdata),
    .rdata_o (main_rdata)
  );

  sram_bank #(
    .NUM_WORDS (USER_WORDS)
  ) u_user_bank (
    .clk_i   (clk_i),
    .req_i   (user_req),
    .we_i    (user_we),
    .idx_i   (user_idx),
    .be_i    (user_be),
    .wdata_i (user_wdata),
    .rdata_o (user_rdata)
  );

  // Watches the core port directly, independent of routing
  exit_monitor u_exit (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .exit_valid_o (exit_valid_o),
    .exit_code_o  (exit_code_o)
  );

endmodule

/* rtl/mem_router.sv */
// Request router, steers each core access to the external slave or an internal bank
module mem_router (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  // Core request
  input  logic                                       req_i,
  input  logic                                       we_i,
  input  mem_sub_pkg::addr_t                         addr_i,
  input  mem_sub_pkg::strb_t                         be_i,
  input  mem_sub_pkg::data_t                         wdata_i,
  // Core response
  output mem_sub_pkg::data_t                         rdata_o,
  output logic                                       rvalid_o,
  // External slave
  input  logic                                       ext_active_i,
  output logic                                       ext_req_o,
  output logic                                       ext_we_o,
  output mem_sub_pkg::addr_t                         ext_addr_o,
  output mem_sub_pkg::strb_t                         ext_be_o,
  output mem_sub_pkg::data_t                         ext_wdata_o,
  input  mem_sub_pkg::data_t                         ext_rdata_i,
  input  logic                                       ext_rvalid_i,
  // Main bank
  output logic                                       main_req_o,
  output logic                                       main_we_o,
  output logic [$clog2(mem_sub_pkg::MAIN_WORDS)-1:0] main_idx_o,
  output mem_sub_pkg::strb_t                         main_be_o,
  output mem_sub_pkg::data_t                         main_wdata_o,
  input  mem_sub_pkg::data_t                         main_rdata_i,
  // User bank
  output logic                                       user_req_o,
  output logic                                       user_we_o,
  output logic [$clog2(mem_sub_pkg::USER_WORDS)-1:0] user_idx_o,
  output mem_sub_pkg::strb_t                         user_be_o,
  output mem_sub_pkg::data_t                         user_wdata_o,
  input  mem_sub_pkg::data_t                         user_rdata_i
);
  import mem_sub_pkg::*;

  localparam int unsigned OFF_W   = $clog2(WORD_BYTES);
  localparam int unsigned MAIN_IW = $clog2(MAIN_WORDS);
  localparam int unsigned USER_IW = $clog2(USER_WORDS);

  region_e req_region;
  addr_t   main_off;
  addr_t   user_off;
  logic    rd_valid_q;
  region_e rd_region_q;

  // ----------------------------------------
  // Request classification
  // ----------------------------------------
  always_comb begin
    if (ext_active_i) begin
      req_region = REGION_EXT;
    end else if (addr_i >= USER_BASE) begin
      req_region = REGION_USER;
    end else begin
      req_region = REGION_MAIN;
    end
  end

  // Byte offsets from each bank base, upper bits drop out so addresses alias
  assign main_off = addr_i - MAIN_BASE;
  assign user_off = addr_i - USER_BASE;

  // ----------------------------------------
  // Bank requests
  // ----------------------------------------
  assign main_req_o   = req_i && (req_region == REGION_MAIN);
  assign main_we_o    = we_i;
  assign main_idx_o   = main_off[MAIN_IW+OFF_W-1:OFF_W];
  assign main_be_o    = be_i;
  assign main_wdata_o = wdata_i;

  assign user_req_o   = req_i && (req_region == REGION_USER);
  assign user_we_o    = we_i;
  assign user_idx_o   = user_off[USER_IW+OFF_W-1:OFF_W];
  assign user_be_o    = be_i;
  assign user_wdata_o = wdata_i;

  // ----------------------------------------
  // External request, held low when unused
  // ----------------------------------------
  assign ext_req_o   = ext_active_i ? req_i : 1'b0;
  assign ext_we_o    = ext_active_i ? we_i : 1'b0;
  assign ext_addr_o  = ext_active_i ? addr_i : '0;
  assign ext_be_o    = ext_active_i ? be_i : '0;
  assign ext_wdata_o = ext_active_i ? wdata_i : '0;

  // ----------------------------------------
  // Read response tracking
  // ----------------------------------------
  // One entry is enough, banks answer in exactly one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_valid_q  <= 1'b0;
      rd_region_q <= REGION_MAIN;
    end else begin
      rd_valid_q  <= req_i && !we_i && (req_region != REGION_EXT);
      rd_region_q <= req_region;
    end
  end

  // Response mux
  always_comb begin
    if (ext_active_i) begin
      rvalid_o = ext_rvalid_i;
      rdata_o  = ext_rdata_i;
    end else begin
      rvalid_o = rd_valid_q;
      rdata_o  = (rd_region_q == REGION_USER) ? user_rdata_i : main_rdata_i;
    end
  end

endmodule

/* rtl/exit_monitor.sv */
// End-of-test detector, latches the first completion write to the tohost word
module exit_monitor (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  mem_sub_pkg::addr_t      addr_i,
  input  mem_sub_pkg::data_t      wdata_i,
  output logic                    exit_valid_o,
  output mem_sub_pkg::exit_code_t exit_code_o
);
  import mem_sub_pkg::*;

  logic       exit_hit;
  logic       exit_valid_q;
  exit_code_t exit_code_q;

  // Bit 0 flags completion, the rest carries the code
  assign exit_hit = req_i && we_i && (addr_i == TOHOST_ADDR) && wdata_i[0]
                    && !exit_valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_code_q  <= '0;
    end else if (exit_hit) begin
      exit_valid_q <= 1'b1;
      exit_code_q  <= wdata_i[31:0] >> 1;
    end
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_code_o  = exit_code_q;

endmodule

/* rtl/sram_bank.sv */
// Single-port word memory with byte enables, instantiated once for each internal bank
module sram_bank #(
  parameter int unsigned NUM_WORDS = 256
) (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] idx_i,
  input  mem_sub_pkg::strb_t           be_i,
  input  mem_sub_pkg::data_t           wdata_i,
  output mem_sub_pkg::data_t           rdata_o
);
  import mem_sub_pkg::*;

  data_t mem_q [NUM_WORDS];
  data_t rdata_q;

  // Starts out all zero like unloaded target memory
  initial begin
    for (int i = 0; i < NUM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------
  // Data lands one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[idx_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* rtl/mem_sub_pkg.sv */
// Shared widths, address map and region encoding, imported by every memory subsystem block
package mem_sub_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned EXIT_W = 32;

  // Bytes per memory word
  localparam int unsigned WORD_BYTES = DATA_W / 8;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [WORD_BYTES-1:0] strb_t;
  typedef logic [EXIT_W-1:0]     exit_code_t;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  // Main memory runs from MAIN_BASE up to USER_BASE
  localparam addr_t MAIN_BASE = 32'h8000_0000;
  // User memory starts here
  localparam addr_t USER_BASE = 32'h8400_0000;

  // Completion word written by the program under test
  localparam addr_t TOHOST_ADDR = 32'h8000_1000;

  // Bank depths in words, powers of two
  localparam int unsigned MAIN_WORDS = 256;
  localparam int unsigned USER_WORDS = 64;

  // ----------------------------------------
  // Request target
  // ----------------------------------------
  typedef enum logic [1:0] {
    REGION_EXT  = 2'd0,
    REGION_MAIN = 2'd1,
    REGION_USER = 2'd2
  } region_e;

endpackage
